//--- Makefile
# Verilator build and run for the remote command link testbench.

SOURCES := $(filter-out +incdir+%,$(shell cat verilog.f))
BIN := obj_dir/Vtb_remote_link

.PHONY: all run clean

all: run

# Rebuilt only when a source, the header or the file list changes.
$(BIN): verilog.f comm_defines.svh $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal -f verilog.f \
		--top-module tb_remote_link -o Vtb_remote_link

# The log decides the result, so a failing run gives a failing status.
run: $(BIN)
	./$(BIN) > sim.log 2>&1; cat sim.log
	grep -q "^PASS: all tests$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- cmd_assembler.sv
`timescale 1ns/1ps
`include "comm_defines.svh"

module cmd_assembler (
  input  logic               clk,          // System clock.
  input  logic               rst_n,        // Async reset, active low.
  input  logic               RX,           // Line from the remote.
  input  logic               clr_cmd_rdy,  // Controller has taken cmd_out.
  input  logic               send_resp,    // Strobe, send resp_in.
  input  logic [`DATA_W-1:0] resp_in,      // Response byte.
  output logic               TX,           // Line to the remote.
  output logic [`CMD_W-1:0]  cmd_out,      // Assembled command.
  output logic               cmd_rdy,      // cmd_out holds a full command.
  output logic               resp_snt      // Response out, held till next send_resp.
);
  import comm_pkg::*;

  asm_state_t state;                // Byte being waited for.
  asm_state_t nxt_state;            // Next state.
  logic [`DATA_W-1:0] high_byte;    // First byte of the command.
  logic [`DATA_W-1:0] rx_data;      // Byte from the UART.
  logic rx_rdy;                     // UART has a byte.
  logic clr_rx_rdy;                 // Byte consumed.
  logic tx_done;                    // Response frame finished.
  logic cap_high;                   // Take the high byte.
  logic cap_low;                    // Take the low byte, command complete.

  uart u_uart (.clk(clk), .rst_n(rst_n), .trmt(send_resp), .tx_data(resp_in), .RX(RX),
               .clr_rx_rdy(clr_rx_rdy), .TX(TX), .tx_done(tx_done), .rx_rdy(rx_rdy),
               .rx_data(rx_data));

  ////////////////////////////////////////
  // Byte join
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (cap_high)
      high_byte <= rx_data;
  end

  // Whole word latched, rx_data moves on with the next frame.
  always_ff @(posedge clk) begin
    if (cap_low)
      cmd_out <= {high_byte, rx_data};
  end

  ////////////////////////////////////////
  // Receive sequencer
  ////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      state <= ASM_HIGH;
    else
      state <= nxt_state;
  end

  always_comb begin
    nxt_state = state;
    cap_high = 1'b0;
    cap_low = 1'b0;
    case (state)
      ASM_LOW: begin
        if (rx_rdy) begin
          cap_low = 1'b1;
          nxt_state = ASM_HIGH;
        end
      end
      default: begin
        if (rx_rdy) begin
          cap_high = 1'b1;          // Also retires the previous command.
          nxt_state = ASM_LOW;
        end
      end
    endcase
  end

  assign clr_rx_rdy = cap_high | cap_low;

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      cmd_rdy <= 1'b0;
    else if (cap_low)
      cmd_rdy <= 1'b1;
    else if (cap_high || clr_cmd_rdy)
      cmd_rdy <= 1'b0;
  end

  ////////////////////////////////////////
  // Response flag
  ////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      resp_snt <= 1'b0;
    else if (send_resp)
      resp_snt <= 1'b0;
    else if (tx_done)
      resp_snt <= 1'b1;             // tx_done is low until the first frame ends.
  end

endmodule

//--- comm_defines.svh
`ifndef COMM_DEFINES_SVH
`define COMM_DEFINES_SVH

////////////////////////////////////////
// Link timing and widths
////////////////////////////////////////

// Clock cycles per UART bit, small to keep simulations short.
`define BAUD_DIV 16

`define DATA_W 8   // One UART byte.

`define CMD_W 16   // One command, sent as two bytes.

`endif

//--- comm_pkg.sv
package comm_pkg;

  ////////////////////////////////////////
  // UART state encodings
  ////////////////////////////////////////
  typedef enum logic [1:0] {TX_IDLE, TX_SHIFT} tx_state_t;  // Serializer.
  typedef enum logic [1:0] {RX_IDLE, RX_SHIFT} rx_state_t;  // Deserializer.

  ////////////////////////////////////////
  // Link end state encodings
  ////////////////////////////////////////

  // Remote end, sending the high byte then the low byte.
  typedef enum logic [1:0] {SND_IDLE, SND_HIGH, SND_LOW} snd_state_t;

  // Robot end, named by the byte it waits for.
  typedef enum logic {ASM_HIGH, ASM_LOW} asm_state_t;

endpackage

//--- remote_comm.sv
`timescale 1ns/1ps
`include "comm_defines.svh"

module remote_comm (
  input  logic               clk,       // System clock.
  input  logic               rst_n,     // Async reset, active low.
  input  logic               snd_cmd,   // Strobe, send cmd.
  input  logic [`CMD_W-1:0]  cmd,       // Command to send, high byte first.
  input  logic               RX,        // Line from the robot.
  output logic               TX,        // Line to the robot.
  output logic [`DATA_W-1:0] resp,      // Last response byte.
  output logic               resp_rdy,  // A response has arrived.
  output logic               cmd_snt    // Both bytes out, held till next snd_cmd.
);
  import comm_pkg::*;

  snd_state_t state;                // Current state.
  snd_state_t nxt_state;            // Next state.
  logic [`DATA_W-1:0] low_byte;     // Low half, kept for the second frame.
  logic [`DATA_W-1:0] tx_byte;      // Byte handed to the UART.
  logic sel_high;                   // Pass the high half straight through.
  logic trmt;                       // Start a UART frame.
  logic tx_done;                    // UART transmitter finished.
  logic set_cmd_snt;                // Second frame finished.

  uart u_uart (.clk(clk), .rst_n(rst_n), .trmt(trmt), .tx_data(tx_byte), .RX(RX),
               .clr_rx_rdy(1'b0), .TX(TX), .tx_done(tx_done), .rx_rdy(resp_rdy),
               .rx_data(resp));

  ////////////////////////////////////////
  // Byte split
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (snd_cmd)
      low_byte <= cmd[`DATA_W-1:0];
  end

  // High byte is only valid in the strobe cycle.
  assign tx_byte = sel_high ? cmd[`CMD_W-1:`DATA_W] : low_byte;

  ////////////////////////////////////////
  // Send sequencer
  ////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      state <= SND_IDLE;
    else
      state <= nxt_state;
  end

  always_comb begin
    nxt_state = state;
    sel_high = 1'b0;
    trmt = 1'b0;
    set_cmd_snt = 1'b0;
    case (state)
      SND_HIGH: begin
        if (tx_done) begin
          trmt = 1'b1;              // High byte out, follow with the low one.
          nxt_state = SND_LOW;
        end
      end
      SND_LOW: begin
        if (tx_done) begin
          set_cmd_snt = 1'b1;
          nxt_state = SND_IDLE;
        end
      end
      default: begin
        if (snd_cmd) begin
          sel_high = 1'b1;
          trmt = 1'b1;
          nxt_state = SND_HIGH;
        end
      end
    endcase
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      cmd_snt <= 1'b0;
    else if (snd_cmd)
      cmd_snt <= 1'b0;              // New command in flight.
    else if (set_cmd_snt)
      cmd_snt <= 1'b1;
  end

  // No back-pressure, so a command must wait for the previous one.
  a_snd_idle: assert property (@(posedge clk) disable iff (!rst_n)
    snd_cmd |-> (state == SND_IDLE))
    else $error("remote_comm: snd_cmd while a command is still sending");

endmodule

//--- remote_link_top.sv
`timescale 1ns/1ps
`include "comm_defines.svh"

module remote_link_top (
  input  logic               clk,          // System clock.
  input  logic               rst_n,        // Async reset, active low.
  input  logic               snd_cmd,      // Remote, send cmd.
  input  logic [`CMD_W-1:0]  cmd,          // Remote, command word.
  output logic               cmd_snt,      // Remote, command gone out.
  output logic [`DATA_W-1:0] resp,         // Remote, response byte.
  output logic               resp_rdy,     // Remote, response arrived.
  output logic [`CMD_W-1:0]  cmd_out,      // Robot, assembled command.
  output logic               cmd_rdy,      // Robot, command valid.
  input  logic               clr_cmd_rdy,  // Robot, command taken.
  input  logic               send_resp,    // Robot, send resp_in.
  input  logic [`DATA_W-1:0] resp_in,      // Robot, response byte.
  output logic               resp_snt,     // Robot, response gone out.
  output logic               tx_remote,    // Line from remote to robot.
  output logic               tx_robot      // Line from robot to remote.
);

  // Each end listens on the other end's TX.
  remote_comm u_remote (.clk(clk), .rst_n(rst_n), .snd_cmd(snd_cmd), .cmd(cmd),
                        .RX(tx_robot), .TX(tx_remote), .resp(resp),
                        .resp_rdy(resp_rdy), .cmd_snt(cmd_snt));

  cmd_assembler u_robot (.clk(clk), .rst_n(rst_n), .RX(tx_remote),
                         .clr_cmd_rdy(clr_cmd_rdy), .send_resp(send_resp),
                         .resp_in(resp_in), .TX(tx_robot), .cmd_out(cmd_out),
                         .cmd_rdy(cmd_rdy), .resp_snt(resp_snt));

endmodule

//--- tb_remote_link.sv
`timescale 1ns/1ps
`include "comm_defines.svh"

module tb_remote_link;

  localparam int TIMEOUT = 25 * `BAUD_DIV;   // Cycles allowed for any single wait.
  localparam int F_CMD_SNT = 0;               // Flag selectors for wait_flag.
  localparam int F_CMD_RDY = 1;
  localparam int F_RESP_RDY = 2;
  localparam int F_RESP_SNT = 3;

  logic               clk;
  logic               rst_n;
  logic               snd_cmd;
  logic [`CMD_W-1:0]  cmd;
  logic               cmd_snt;
  logic [`DATA_W-1:0] resp;
  logic               resp_rdy;
  logic [`CMD_W-1:0]  cmd_out;
  logic               cmd_rdy;
  logic               clr_cmd_rdy;
  logic               send_resp;
  logic [`DATA_W-1:0] resp_in;
  logic               resp_snt;
  logic               tx_remote;
  logic               tx_robot;

  int errors;                                 // Wrong values seen.
  int timeouts;                               // Waits that ran out.

  remote_link_top dut (.clk(clk), .rst_n(rst_n), .snd_cmd(snd_cmd), .cmd(cmd),
                       .cmd_snt(cmd_snt), .resp(resp), .resp_rdy(resp_rdy),
                       .cmd_out(cmd_out), .cmd_rdy(cmd_rdy), .clr_cmd_rdy(clr_cmd_rdy),
                       .send_resp(send_resp), .resp_in(resp_in), .resp_snt(resp_snt),
                       .tx_remote(tx_remote), .tx_robot(tx_robot));

  always #4 clk = ~clk;                       // 8 ns period.

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // Moves to 1 ns after the next rising edge.
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic report_fail(input string msg);
    errors++;
    $display("FAIL at %0t ns: %s", $time, msg);
  endtask

  function automatic logic flag_value(input int which);
    case (which)
      F_CMD_SNT:  return cmd_snt;
      F_CMD_RDY:  return cmd_rdy;
      F_RESP_RDY: return resp_rdy;
      F_RESP_SNT: return resp_snt;
      default:    return 1'bx;
    endcase
  endfunction

  task automatic wait_flag(input int which, input logic level, input string what);
    int cycles;
    cycles = 0;
    while ((flag_value(which) !== level) && (cycles < TIMEOUT)) begin
      step();
      cycles++;
    end
    if (flag_value(which) !== level) begin
      timeouts++;
      $display("Timeout at %0t ns: %s never happened in %0d cycles", $time, what, TIMEOUT);
    end
  endtask

  // High byte is only used in the strobe cycle, so cmd is scrambled after it.
  task automatic send_command(input logic [`CMD_W-1:0] value);
    cmd = value;
    snd_cmd = 1'b1;
    step();
    snd_cmd = 1'b0;
    cmd = ~value;
  endtask

  task automatic clear_command();
    clr_cmd_rdy = 1'b1;
    step();
    clr_cmd_rdy = 1'b0;
    if (cmd_rdy !== 1'b0)
      report_fail("cmd_rdy did not fall after clr_cmd_rdy");
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////
  task automatic check_reset_state();
    if ((tx_remote !== 1'b1) || (tx_robot !== 1'b1))
      report_fail("serial lines not idle high after reset");
    if ((cmd_snt !== 1'b0) || (resp_rdy !== 1'b0) || (cmd_rdy !== 1'b0) || (resp_snt !== 1'b0))
      report_fail("a status flag is not low after reset");
  endtask

  task automatic deliver_one_command();
    send_command(16'hA53C);
    if (cmd_snt !== 1'b0)
      report_fail("cmd_snt not low after snd_cmd");
    wait_flag(F_CMD_RDY, 1'b1, "cmd_rdy rising for 16'hA53C");
    if (cmd_out !== 16'hA53C)
      report_fail($sformatf("cmd_out %h, expected a53c", cmd_out));
    if (cmd_snt !== 1'b0)
      report_fail("cmd_snt already high when cmd_rdy rose");
    wait_flag(F_CMD_SNT, 1'b1, "cmd_snt rising for 16'hA53C");
    clear_command();
  endtask

  // Byte is scrambled after the strobe, the transmitter must hold its own copy.
  task automatic return_one_response(input logic [`DATA_W-1:0] value);
    resp_in = value;
    send_resp = 1'b1;
    step();
    send_resp = 1'b0;
    resp_in = ~value;
    wait_flag(F_RESP_RDY, 1'b1, "resp_rdy rising");
    if (resp !== value)
      report_fail($sformatf("resp %h, expected %h", resp, value));
    wait_flag(F_RESP_SNT, 1'b1, "resp_snt rising");
  endtask

  task automatic deliver_random_commands();
    logic [`CMD_W-1:0] value;
    for (int i = 0; i < 20; i++) begin
      value = `CMD_W'($urandom);
      send_command(value);
      wait_flag(F_CMD_SNT, 1'b1, $sformatf("cmd_snt rising for random command %0d", i));
      if ((cmd_rdy !== 1'b1) || (cmd_out !== value))
        report_fail($sformatf("random %0d: cmd_out %h rdy %b, expected %h",
                              i, cmd_out, cmd_rdy, value));
      clear_command();
    end
  endtask

  // The first command is not cleared. Its cmd_rdy is still high for the second.
  task automatic new_command_clears_flags();
    send_command(16'h1234);
    wait_flag(F_CMD_SNT, 1'b1, "cmd_snt rising for 16'h1234");
    send_command(16'hBEEF);
    if (cmd_snt !== 1'b0)
      report_fail("cmd_snt not cleared by a new snd_cmd");
    if ((cmd_rdy !== 1'b1) || (cmd_out !== 16'h1234))
      report_fail("previous command lost before the new high byte");
    wait_flag(F_CMD_RDY, 1'b0, "cmd_rdy falling on the new high byte");
    if (cmd_out !== 16'h1234)
      report_fail($sformatf("cmd_out %h changed early, expected 1234", cmd_out));
    wait_flag(F_CMD_RDY, 1'b1, "cmd_rdy rising for 16'hBEEF");
    if (cmd_out !== 16'hBEEF)
      report_fail($sformatf("cmd_out %h, expected beef", cmd_out));
    wait_flag(F_CMD_SNT, 1'b1, "cmd_snt rising for 16'hBEEF");
    clear_command();
  endtask

  // Both strobes come in one cycle. Each line carries one direction.
  task automatic run_full_duplex();
    logic [`CMD_W-1:0] value;
    logic [`DATA_W-1:0] byte_val;
    value = `CMD_W'($urandom);
    byte_val = `DATA_W'($urandom);
    cmd = value;
    resp_in = byte_val;
    snd_cmd = 1'b1;
    send_resp = 1'b1;
    step();
    snd_cmd = 1'b0;
    send_resp = 1'b0;
    cmd = ~value;
    resp_in = ~byte_val;
    if ((cmd_snt !== 1'b0) || (resp_snt !== 1'b0))
      report_fail("cmd_snt or resp_snt not cleared by the new strobes");
    wait_flag(F_RESP_RDY, 1'b0, "resp_rdy clearing at the new response frame");
    wait_flag(F_RESP_RDY, 1'b1, "resp_rdy rising in full duplex");
    if (resp !== byte_val)
      report_fail($sformatf("duplex resp %h, expected %h", resp, byte_val));
    wait_flag(F_CMD_RDY, 1'b1, "cmd_rdy rising in full duplex");
    if (cmd_out !== value)
      report_fail($sformatf("duplex cmd_out %h, expected %h", cmd_out, value));
    wait_flag(F_CMD_SNT, 1'b1, "cmd_snt rising in full duplex");
    wait_flag(F_RESP_SNT, 1'b1, "resp_snt rising in full duplex");
  endtask

  ////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////
  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    snd_cmd = 1'b0;
    cmd = '0;
    clr_cmd_rdy = 1'b0;
    send_resp = 1'b0;
    resp_in = '0;
    errors = 0;
    timeouts = 0;
    void'($urandom(32'h68e1));               // One seed for the whole run.
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    step();
    check_reset_state();
    deliver_one_command();
    return_one_response(8'hC7);
    deliver_random_commands();
    new_command_clears_flags();
    run_full_duplex();
    $display("Errors: %0d, timeouts: %0d", errors, timeouts);
    if ((errors == 0) && (timeouts == 0))
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

//--- uart.sv
`timescale 1ns/1ps
`include "comm_defines.svh"

module uart (
  input  logic               clk,         // System clock.
  input  logic               rst_n,       // Async reset, active low.
  input  logic               trmt,        // Send tx_data.
  input  logic [`DATA_W-1:0] tx_data,     // Byte to send.
  input  logic               RX,          // Serial input.
  input  logic               clr_rx_rdy,  // Consumer has taken rx_data.
  output logic               TX,          // Serial output.
  output logic               tx_done,     // Transmitter idle after a frame.
  output logic               rx_rdy,      // A received byte is waiting.
  output logic [`DATA_W-1:0] rx_data      // Received byte.
);
  logic rx_start;                         // New frame began.
  logic rx_done;                          // Frame complete.

  uart_tx u_tx (.clk(clk), .rst_n(rst_n), .trmt(trmt), .tx_data(tx_data),
                .TX(TX), .tx_done(tx_done));

  uart_rx u_rx (.clk(clk), .rst_n(rst_n), .RX(RX), .rx_data(rx_data),
                .rx_start(rx_start), .rx_done(rx_done));

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      rx_rdy <= 1'b0;
    else if (rx_start || clr_rx_rdy)
      rx_rdy <= 1'b0;               // Byte read, or about to be overwritten.
    else if (rx_done)
      rx_rdy <= 1'b1;
  end

endmodule

//--- uart_rx.sv
`timescale 1ns/1ps
`include "comm_defines.svh"

module uart_rx (
  input  logic               clk,       // System clock.
  input  logic               rst_n,     // Async reset, active low.
  input  logic               RX,        // Serial line, asynchronous.
  output logic [`DATA_W-1:0] rx_data,   // Last received byte.
  output logic               rx_start,  // Pulse on a start bit edge.
  output logic               rx_done    // Pulse when the stop bit is sampled.
);
  import comm_pkg::*;

  localparam int BAUD_W = $clog2(`BAUD_DIV);
  localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(`BAUD_DIV - 1);
  localparam logic [BAUD_W-1:0] BAUD_HALF = BAUD_W'(`BAUD_DIV / 2 - 1);
  localparam logic [3:0] BIT_LAST = 4'(`DATA_W + 1);             // Stop bit index.

  rx_state_t state;                 // Current state.
  rx_state_t nxt_state;             // Next state.
  logic rx_ff1;                     // First sync stage.
  logic rx_sync;                    // Synchronized line.
  logic rx_prev;                    // Line one cycle earlier, for edge detect.
  logic [BAUD_W-1:0] baud_cnt;      // Down counter to the next sample.
  logic [3:0] bit_cnt;              // Samples taken in this frame.
  logic [`DATA_W:0] rx_sr;          // Stop bit and data after a full frame.
  logic sample;                     // Sample point reached.

  ////////////////////////////////////////
  // Input synchronizer
  ////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      rx_ff1 <= 1'b1;               // Idle level, so no false start.
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_ff1 <= RX;
      rx_sync <= rx_ff1;
      rx_prev <= rx_sync;
    end
  end

  assign sample = (state == RX_SHIFT) && (baud_cnt == '0);

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      baud_cnt <= '0;
    else if (rx_start)
      baud_cnt <= BAUD_HALF;        // First sample lands mid start bit.
    else if (sample)
      baud_cnt <= BAUD_LAST;        // Then one full bit apart.
    else if (state == RX_SHIFT)
      baud_cnt <= baud_cnt - 1'b1;
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      bit_cnt <= '0;
    else if (rx_start)
      bit_cnt <= '0;
    else if (sample)
      bit_cnt <= bit_cnt + 1'b1;
  end

  // Start bit falls off the bottom after the last shift.
  always_ff @(posedge clk) begin
    if (sample)
      rx_sr <= {rx_sync, rx_sr[`DATA_W:1]};
  end

  assign rx_data = rx_sr[`DATA_W-1:0];

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      state <= RX_IDLE;
    else
      state <= nxt_state;
  end

  always_comb begin
    nxt_state = state;
    rx_start = 1'b0;
    rx_done = 1'b0;
    case (state)
      RX_SHIFT: begin
        if (sample && (bit_cnt == BIT_LAST)) begin
          rx_done = 1'b1;           // Stop bit taken, no framing check.
          nxt_state = RX_IDLE;
        end
      end
      default: begin
        if (rx_prev && !rx_sync) begin
          rx_start = 1'b1;          // Falling edge opens a frame.
          nxt_state = RX_SHIFT;
        end
      end
    endcase
  end

endmodule

//--- uart_tx.sv
`timescale 1ns/1ps
`include "comm_defines.svh"

module uart_tx (
  input  logic               clk,      // System clock.
  input  logic               rst_n,    // Async reset, active low.
  input  logic               trmt,     // Starts a frame.
  input  logic [`DATA_W-1:0] tx_data,  // Byte to send.
  output logic               TX,       // Serial line, idles high.
  output logic               tx_done   // High from end of stop bit to next trmt.
);
  import comm_pkg::*;

  localparam int FRAME_BITS = `DATA_W + 2;                       // Start, data, stop.
  localparam int BAUD_W = $clog2(`BAUD_DIV);
  localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(`BAUD_DIV - 1);
  localparam logic [3:0] BIT_LAST = 4'(FRAME_BITS - 1);

  tx_state_t state;                 // Current state.
  tx_state_t nxt_state;             // Next state.
  logic [FRAME_BITS-1:0] tx_sr;     // Frame being shifted out, LSB first.
  logic [BAUD_W-1:0] baud_cnt;      // Cycles within the current bit.
  logic [3:0] bit_cnt;              // Bits already shifted.
  logic load;                       // Load a new frame.
  logic shift;                      // End of a bit period.
  logic set_done;                   // Stop bit finished.

  assign shift = (state == TX_SHIFT) && (baud_cnt == BAUD_LAST);
  assign TX = tx_sr[0];             // Line follows the register LSB.

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      tx_sr <= '1;                                   // Keeps the line idle high.
    else if (load)
      tx_sr <= {1'b1, tx_data, 1'b0};                // Stop, data, start.
    else if (shift)
      tx_sr <= {1'b1, tx_sr[FRAME_BITS-1:1]};        // Fill with idle level.
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      baud_cnt <= '0;
    else if (load || shift)
      baud_cnt <= '0;                                // Restart for the next bit.
    else if (state == TX_SHIFT)
      baud_cnt <= baud_cnt + 1'b1;
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      bit_cnt <= '0;
    else if (load)
      bit_cnt <= '0;
    else if (shift)
      bit_cnt <= bit_cnt + 1'b1;
  end

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      state <= TX_IDLE;
    else
      state <= nxt_state;
  end

  always_comb begin
    nxt_state = state;              // Hold by default.
    load = 1'b0;
    set_done = 1'b0;
    case (state)
      TX_SHIFT: begin
        if (shift && (bit_cnt == BIT_LAST)) begin
          set_done = 1'b1;          // Last bit was the stop bit.
          nxt_state = TX_IDLE;
        end
      end
      default: begin
        if (trmt) begin
          load = 1'b1;
          nxt_state = TX_SHIFT;
        end
      end
    endcase
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      tx_done <= 1'b0;
    else if (trmt)
      tx_done <= 1'b0;              // Knocked down by a new frame.
    else if (set_done)
      tx_done <= 1'b1;              // Held until the next trmt.
  end

  // A new frame may only be requested once the previous one is out.
  a_trmt_idle: assert property (@(posedge clk) disable iff (!rst_n)
    trmt |-> (state == TX_IDLE))
    else $error("uart_tx: trmt arrived while a frame was shifting");

endmodule

//--- verilog.f
+incdir+.
comm_pkg.sv
uart_tx.sv
uart_rx.sv
uart.sv
remote_comm.sv
cmd_assembler.sv
remote_link_top.sv
tb_remote_link.sv
